// ==== hc_loopback.f ====
verilog/hc_bus_pkg.sv
verilog/hc_csr_pkg.sv
verilog/hc_csr.sv
verilog/hc_copy_fsm.sv
verilog/hc_line_counter.sv
verilog/hc_line_mem.sv
verilog/hc_loopback_top.sv
verif/hc_loopback_properties.sv
verif/hc_loopback_tb.sv

// ==== Makefile ====
# Verilator build and run for the loopback engine testbench

VERILATOR ?= verilator
TOP       ?= hc_loopback_tb
FILELIST  ?= hc_loopback.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?=

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# The exit status of the simulator is the test result
run: $(BIN)
	./$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/hc_loopback_tb.sv ====
// Testbench for the loopback engine that drives Wishbone traffic and checks memory and status
module hc_loopback_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int AW           = hc_bus_pkg::ADDR_W;
    localparam int MAW          = hc_bus_pkg::MEM_AW;
    localparam int MEM_WORDS    = 1 << hc_bus_pkg::MEM_AW;
    localparam int NUM_COPIES   = 6;

    // The full-length copy, the random copies and the start with the channel disabled
    localparam int NUM_TESTS    = NUM_COPIES + 2;

    // Register setup, the memory fill and every readback; status polls sit in the test budget
    localparam int NUM_ACCESSES = 16 + 3 * MEM_WORDS + NUM_COPIES * (MEM_WORDS + 6) + 8;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + NUM_ACCESSES * 10;

    logic                clk;
    logic                reset;
    hc_bus_pkg::wb_req_t wb_req;
    hc_bus_pkg::wb_rsp_t wb_rsp;

    // Mirror of the line memory that follows the engine's copy rules
    logic [31:0] ref_mem [MEM_WORDS];
    int unsigned base_addr;
    logic [7:0]  tests_done_exp;

    hc_loopback_top i_hc_loopback_top
    (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    // Handshake and engine timing are watched inside the DUT
    bind hc_loopback_top hc_loopback_properties i_hc_loopback_properties
    (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .csr    (csr),
        .status (status)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles before all tests completed", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $fatal(1);
    end

    // Watches the bound checker for a failed property
    initial
    begin
        wait (i_hc_loopback_top.i_hc_loopback_properties.failures != 0);
        $display("A bound timing property failed at time %0t", $time);
        $display("Finished with errors");
        $fatal(1);
    end

    // Word address of a register or memory offset, relative to the block base
    function automatic logic [AW-1:0] reg_addr(input int offset);
        return AW'(base_addr + offset);
    endfunction

    // Status layout is busy above the finished-test count
    function automatic logic [31:0] expected_status(input logic busy, input logic [7:0] done);
        return {23'd0, busy, done};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch at time %0t: %s read 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // One classic cycle holds the request until ack and releases it on the following edge
    task automatic access_bus(input logic we, input logic [AW-1:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= wdata;
        // Ack and read data come from registers, so they are settled at the falling edge
        @(negedge clk);
        while (!wb_rsp.ack)
            @(negedge clk);
        rdata = wb_rsp.dat;
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic write_bus(input logic [AW-1:0] adr, input logic [31:0] wdata);
        logic [31:0] ignored;
        access_bus(1'b1, adr, wdata, ignored);
    endtask

    task automatic read_bus(input logic [AW-1:0] adr, output logic [31:0] rdata);
        access_bus(1'b0, adr, 32'd0, rdata);
    endtask

    // Reads the whole window back and compares it with the mirror
    task automatic check_memory();
        logic [31:0] word;
        int          i;
        for (i = 0; i < MEM_WORDS; i++)
        begin
            read_bus(reg_addr(hc_csr_pkg::MEM_WINDOW + i), word);
            check_value($sformatf("memory word %0d", i), word, ref_mem[MAW'(i)]);
        end
    endtask

    // Runs one copy and polls status until busy clears
    task automatic copy_test(input int len, input int rf, input int wf, input bit restart);
        logic [31:0] status_word;
        int          i;
        write_bus(reg_addr(hc_csr_pkg::CSR_HC_READ_FRAME), 32'(rf));
        write_bus(reg_addr(hc_csr_pkg::CSR_HC_WRITE_FRAME), 32'(wf));
        // A full line is written as length zero
        write_bus(reg_addr(hc_csr_pkg::CSR_HC_ENABLE_TEST), 32'(len % MEM_WORDS));
        // Second start lands while the first copy still runs and must be dropped
        if (restart)
            write_bus(reg_addr(hc_csr_pkg::CSR_HC_ENABLE_TEST),
                      32'($urandom_range(MEM_WORDS - 1, 1)));
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_STATUS), status_word);
        while (status_word[hc_csr_pkg::TESTS_W])
            read_bus(reg_addr(hc_csr_pkg::CSR_HC_STATUS), status_word);
        for (i = 0; i < len; i++)
            ref_mem[MAW'(wf + i)] = ref_mem[MAW'(rf + i)];
        tests_done_exp = tests_done_exp + 8'd1;
        check_value("status after copy", status_word, expected_status(1'b0, tests_done_exp));
    endtask

    initial
    begin
        logic [31:0] word;
        int          len;
        int          rf;
        int          wf;
        int          t;
        int          i;

        void'($urandom(32'h2d78_fb8b));
        reset          = 1'b1;
        wb_req         = '0;
        tests_done_exp = '0;
        base_addr      = i_hc_loopback_top.CSR_BASE_ADDR;
        repeat (RESET_CYCLES)
            @(posedge clk);
        reset <= 1'b0;

        // Idle state straight out of reset
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_STATUS), word);
        check_value("status after reset", word, expected_status(1'b0, 8'd0));
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_EN), word);
        check_value("hc_en after reset", word, 32'd0);

        // First offset past the status register is not decoded
        write_bus(reg_addr(hc_csr_pkg::CSR_HC_STATUS + 1), $urandom());
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_STATUS + 1), word);
        check_value("undecoded register", word, 32'd0);

        write_bus(reg_addr(hc_csr_pkg::CSR_HC_EN), 32'd1);
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_EN), word);
        check_value("hc_en after enable", word, 32'd1);

        // Full-line copy onto itself while the contents are still unknown
        copy_test(MEM_WORDS, 0, 0, 1'b0);

        for (i = 0; i < MEM_WORDS; i++)
        begin
            ref_mem[MAW'(i)] = $urandom();
            write_bus(reg_addr(hc_csr_pkg::MEM_WINDOW + i), ref_mem[MAW'(i)]);
        end
        // A few overwrites at random places
        repeat (16)
        begin
            i = $urandom_range(MEM_WORDS - 1, 0);
            ref_mem[MAW'(i)] = $urandom();
            write_bus(reg_addr(hc_csr_pkg::MEM_WINDOW + i), ref_mem[MAW'(i)]);
        end
        check_memory();

        // Frames are placed so the two ranges never share a word
        for (t = 0; t < NUM_COPIES; t++)
        begin
            len = (t == 0) ? $urandom_range(MEM_WORDS / 2, 8) : $urandom_range(MEM_WORDS / 2, 1);
            rf  = $urandom_range(MEM_WORDS - 1, 0);
            wf  = (rf + len + $urandom_range(MEM_WORDS - 2 * len, 0)) % MEM_WORDS;
            copy_test(len, rf, wf, len >= 8);
            read_bus(reg_addr(hc_csr_pkg::CSR_HC_WRITE_FRAME), word);
            check_value("write frame", word, 32'(wf));
            check_memory();
        end

        // With the channel off a start write must do nothing
        write_bus(reg_addr(hc_csr_pkg::CSR_HC_EN), 32'd0);
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_EN), word);
        check_value("hc_en after disable", word, 32'd0);
        write_bus(reg_addr(hc_csr_pkg::CSR_HC_ENABLE_TEST), 32'd5);
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_STATUS), word);
        check_value("status after disabled start", word, expected_status(1'b0, tests_done_exp));
        check_memory();
        read_bus(reg_addr(hc_csr_pkg::CSR_HC_STATUS), word);
        check_value("final status", word, expected_status(1'b0, tests_done_exp));

        if (i_hc_loopback_top.i_hc_loopback_properties.failures != 0)
        begin
            $display("Finished with errors");
            $fatal(1);
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== verif/hc_loopback_properties.sv ====
// Concurrent checks on Wishbone ack timing, the start pulse and copy engine busy length
module hc_loopback_properties
(
    input logic                   clk,
    input logic                   reset,
    input hc_bus_pkg::wb_req_t    wb_req,
    input hc_bus_pkg::wb_rsp_t    wb_rsp,
    input hc_csr_pkg::hc_csrs_t   csr,
    input hc_csr_pkg::hc_status_t status
);

    timeunit 1ns;
    timeprecision 100ps;

    logic                         req;
    logic [7:0]                   busy_cycles;
    logic [hc_csr_pkg::LEN_W-1:0] busy_len;

    // Number of properties that have failed so far
    int unsigned                  failures = 0;

    assign req = wb_req.cyc && wb_req.stb;

    // Cycles in the current busy stretch, cleared while idle
    always_ff @(posedge clk)
    begin
        if (reset)
            busy_cycles <= '0;
        else if (status.busy)
            busy_cycles <= busy_cycles + 8'd1;
        else
            busy_cycles <= '0;
    end

    // Length in force when busy rose; a later start write may change the register
    always_ff @(posedge clk)
    begin
        if (status.busy && busy_cycles == 8'd0)
            busy_len <= csr.hc_test_len;
    end

    // Ack only answers a request seen one cycle earlier
    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> $past(req))
    else
    begin
        failures++;
        $error("Ack without a request in the previous cycle");
    end

    ack_follows_request: assert property (@(posedge clk) disable iff (reset)
        req && !wb_rsp.ack |=> wb_rsp.ack)
    else
    begin
        failures++;
        $error("Request not acked one cycle after it was seen");
    end

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
    else
    begin
        failures++;
        $error("Ack held for more than one cycle");
    end

    start_single: assert property (@(posedge clk) disable iff (reset)
        csr.hc_enable_test |=> !csr.hc_enable_test)
    else
    begin
        failures++;
        $error("Start pulse longer than one cycle");
    end

    // The pulse comes from a write accepted while the channel was on
    start_needs_enable: assert property (@(posedge clk) disable iff (reset)
        csr.hc_enable_test |-> $past(csr.hc_en))
    else
    begin
        failures++;
        $error("Start pulse with the channel disabled");
    end

    // N reads plus the final write-back, so a restart would stretch this
    busy_length: assert property (@(posedge clk) disable iff (reset)
        $fell(status.busy) |-> busy_cycles == 8'(busy_len) + 8'd1)
    else
    begin
        failures++;
        $error("Busy length differs from test length plus one");
    end

    tests_done_step: assert property (@(posedge clk) disable iff (reset)
        $fell(status.busy) |-> status.tests_done == $past(status.tests_done) + 8'd1)
    else
    begin
        failures++;
        $error("Finished-test count did not step as busy fell");
    end

    tests_done_hold: assert property (@(posedge clk) disable iff (reset)
        !$fell(status.busy) |-> $stable(status.tests_done))
    else
    begin
        failures++;
        $error("Finished-test count changed outside the end of a test");
    end

endmodule

// ==== verilog/hc_loopback_top.sv ====
// Loopback engine top that joins the register block, copy FSM, word counter and line memory
module hc_loopback_top
#(
    parameter int CSR_BASE_ADDR = 0
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  hc_bus_pkg::wb_req_t     wb_req,
    output hc_bus_pkg::wb_rsp_t     wb_rsp
);

    hc_csr_pkg::hc_csrs_t               csr;
    hc_csr_pkg::hc_status_t             status;

    // Bus side of the line memory
    hc_bus_pkg::mem_port_t              mem_a;
    logic [hc_bus_pkg::DATA_W-1:0]      mem_a_rd_data;

    // Engine side of the line memory
    hc_bus_pkg::mem_port_t              mem_rd;
    hc_bus_pkg::mem_port_t              mem_wr;
    logic [hc_bus_pkg::DATA_W-1:0]      rd_data_b;

    // Counter handshake
    logic                               load;
    logic                               step;
    logic [hc_bus_pkg::MEM_AW-1:0]      index;
    logic                               last;

    hc_csr #(
        .CSR_BASE_ADDR (CSR_BASE_ADDR)
    ) i_hc_csr (
        .clk           (clk),
        .reset         (reset),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .mem_a         (mem_a),
        .mem_a_rd_data (mem_a_rd_data),
        .status        (status),
        .csr           (csr)
    );

    hc_copy_fsm i_hc_copy_fsm (
        .clk     (clk),
        .reset   (reset),
        .csr     (csr),
        .load    (load),
        .step    (step),
        .index   (index),
        .last    (last),
        .mem_rd  (mem_rd),
        .mem_wr  (mem_wr),
        .rd_data (rd_data_b),
        .status  (status)
    );

    // Length comes straight from the register block and is taken on load
    hc_line_counter i_hc_line_counter (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .step  (step),
        .len   (csr.hc_test_len),
        .index (index),
        .last  (last)
    );

    hc_line_mem i_hc_line_mem (
        .clk       (clk),
        .port_a    (mem_a),
        .rd_data_a (mem_a_rd_data),
        .rd_b      (mem_rd),
        .rd_data_b (rd_data_b),
        .wr_b      (mem_wr)
    );

endmodule

// ==== verilog/hc_line_mem.sv ====
// Line memory of 64 words with a bus port and separate engine read and write ports
module hc_line_mem
(
    input  logic                              clk,
    input  hc_bus_pkg::mem_port_t             port_a,
    output logic [hc_bus_pkg::DATA_W-1:0]     rd_data_a,
    input  hc_bus_pkg::mem_port_t             rd_b,
    output logic [hc_bus_pkg::DATA_W-1:0]     rd_data_b,
    input  hc_bus_pkg::mem_port_t             wr_b
);

    localparam int DEPTH = 1 << hc_bus_pkg::MEM_AW;

    logic [hc_bus_pkg::DATA_W-1:0] mem [DEPTH];

    // Bus port reads the old word on a write, data comes out on the next edge
    always_ff @(posedge clk)
    begin
        if (port_a.en)
        begin
            if (port_a.we)
                mem[port_a.addr] <= port_a.wdata;
            rd_data_a <= mem[port_a.addr];
        end
        // Engine write-back; a clash with the bus on one word is left undefined
        if (wr_b.en && wr_b.we)
            mem[wr_b.addr] <= wr_b.wdata;
    end

    // Engine read port, registered like the bus port
    always_ff @(posedge clk)
    begin
        if (rd_b.en)
            rd_data_b <= mem[rd_b.addr];
    end

endmodule

// ==== verilog/hc_line_counter.sv ====
// Loadable down-counter of words left in a copy, with running word index and last-word flag
module hc_line_counter
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              load,
    input  logic                              step,
    input  logic [hc_csr_pkg::LEN_W-1:0]      len,
    output logic [hc_bus_pkg::MEM_AW-1:0]     index,
    output logic                              last
);

    localparam int LW = hc_csr_pkg::LEN_W;

    // Words still to issue after the current one, and the index of the next word
    logic [LW-1:0]                      remain_q;
    logic [hc_bus_pkg::MEM_AW-1:0]      index_q;

    // The load cycle issues word 0 itself, so the registers start one word ahead
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            remain_q <= '0;
            index_q  <= '0;
        end
        else if (load)
        begin
            remain_q <= len - LW'(1);
            index_q  <= 1;
        end
        else if (step)
        begin
            remain_q <= remain_q - LW'(1);
            index_q  <= index_q + 1'b1;
        end
    end

    // On load the outputs describe word 0 of the new count
    assign index = load ? '0 : index_q;
    assign last  = load ? (len == LW'(1)) : (remain_q == LW'(1));

endmodule

// ==== verilog/hc_copy_fsm.sv ====
// Copy engine FSM that moves a line of words from the read frame to the write frame
module hc_copy_fsm
(
    input  logic                              clk,
    input  logic                              reset,
    input  hc_csr_pkg::hc_csrs_t              csr,
    output logic                              load,
    output logic                              step,
    input  logic [hc_bus_pkg::MEM_AW-1:0]     index,
    input  logic                              last,
    output hc_bus_pkg::mem_port_t             mem_rd,
    output hc_bus_pkg::mem_port_t             mem_wr,
    input  logic [hc_bus_pkg::DATA_W-1:0]     rd_data,
    output hc_csr_pkg::hc_status_t            status
);

    typedef enum logic [1:0] {ST_IDLE, ST_COPY, ST_DRAIN} state_t;

    state_t                             state_q;
    state_t                             state_d;
    logic                               start;
    logic                               rd_issue;
    logic                               wr_valid_q;
    logic [hc_bus_pkg::MEM_AW-1:0]      wr_addr_q;
    logic [hc_csr_pkg::TESTS_W-1:0]     tests_done_q;

    // A pulse outside idle is dropped, so a running test is never restarted
    assign start = (state_q == ST_IDLE) && csr.hc_enable_test;

    // First read goes out with the pulse itself, the rest follow back to back
    assign rd_issue = start || (state_q == ST_COPY);
    assign load     = start;
    assign step     = (state_q == ST_COPY);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
                if (csr.hc_enable_test)
                    state_d = last ? ST_DRAIN : ST_COPY;
            ST_COPY:
                if (last)
                    state_d = ST_DRAIN;
            default:
                state_d = ST_IDLE;
        endcase
    end

    // Frame plus index wraps around the 64-word memory
    always_comb
    begin
        mem_rd.en    = rd_issue;
        mem_rd.we    = 1'b0;
        mem_rd.addr  = csr.hc_read_frame + index;
        mem_rd.wdata = '0;
        // Write-back of the word read one cycle earlier
        mem_wr.en    = wr_valid_q;
        mem_wr.we    = 1'b1;
        mem_wr.addr  = wr_addr_q;
        mem_wr.wdata = rd_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q      <= ST_IDLE;
            wr_valid_q   <= 1'b0;
            tests_done_q <= '0;
        end
        else
        begin
            state_q    <= state_d;
            wr_valid_q <= rd_issue;
            // Drain holds the final write, so the count moves as busy drops
            if (state_q == ST_DRAIN)
                tests_done_q <= tests_done_q + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_issue)
            wr_addr_q <= csr.hc_write_frame + index;
    end

    // Busy covers the pulse cycle through the cycle of the last write
    assign status.busy       = start || (state_q != ST_IDLE);
    assign status.tests_done = tests_done_q;

endmodule

// ==== verilog/hc_csr.sv ====
// Wishbone register block that decodes host writes, forwards the memory window and returns data
module hc_csr
#(
    parameter int CSR_BASE_ADDR = 0
)
(
    input  logic                                clk,
    input  logic                                reset,
    input  hc_bus_pkg::wb_req_t                 wb_req,
    output hc_bus_pkg::wb_rsp_t                 wb_rsp,
    output hc_bus_pkg::mem_port_t               mem_a,
    input  logic [hc_bus_pkg::DATA_W-1:0]       mem_a_rd_data,
    input  hc_csr_pkg::hc_status_t              status,
    output hc_csr_pkg::hc_csrs_t                csr
);

    localparam int AW = hc_bus_pkg::ADDR_W;
    localparam int DW = hc_bus_pkg::DATA_W;
    localparam int MEM_WORDS = 1 << hc_bus_pkg::MEM_AW;
    localparam int LW = hc_csr_pkg::LEN_W;

    // Source of the read data returned with the next ack
    typedef enum logic [2:0] {SEL_NONE, SEL_MEM, SEL_EN, SEL_RFRAME, SEL_WFRAME, SEL_STATUS} rd_sel_t;

    logic          accept;
    logic [AW-1:0] rel_addr;
    logic          win_hit;
    logic          ack_q;
    rd_sel_t       rd_sel_d;
    rd_sel_t       rd_sel_q;

    // An access is taken in its first stb cycle; the ack cycle itself is never taken again
    assign accept   = wb_req.cyc && wb_req.stb && !ack_q;
    assign rel_addr = wb_req.adr - AW'(CSR_BASE_ADDR);
    assign win_hit  = (rel_addr >= AW'(hc_csr_pkg::MEM_WINDOW)) &&
                      (rel_addr <  AW'(hc_csr_pkg::MEM_WINDOW + MEM_WORDS));

    // True for a write accepted this cycle at the given register offset
    function automatic logic wr_hit(int offset);
        return accept && wb_req.we && (rel_addr == AW'(offset));
    endfunction

    // Memory window accesses go straight to port A for one cycle
    always_comb
    begin
        mem_a.en    = accept && win_hit;
        mem_a.we    = wb_req.we;
        mem_a.addr  = rel_addr[hc_bus_pkg::MEM_AW-1:0];
        mem_a.wdata = wb_req.dat;
    end

    // Pick the read source now, return its data in the ack cycle
    always_comb
    begin
        rd_sel_d = SEL_NONE;
        if (accept && !wb_req.we)
        begin
            if (win_hit)
                rd_sel_d = SEL_MEM;
            else if (rel_addr == AW'(hc_csr_pkg::CSR_HC_EN))
                rd_sel_d = SEL_EN;
            else if (rel_addr == AW'(hc_csr_pkg::CSR_HC_READ_FRAME))
                rd_sel_d = SEL_RFRAME;
            else if (rel_addr == AW'(hc_csr_pkg::CSR_HC_WRITE_FRAME))
                rd_sel_d = SEL_WFRAME;
            else if (rel_addr == AW'(hc_csr_pkg::CSR_HC_STATUS))
                rd_sel_d = SEL_STATUS;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack_q    <= 1'b0;
            rd_sel_q <= SEL_NONE;
        end
        else
        begin
            ack_q    <= accept;
            rd_sel_q <= rd_sel_d;
        end
    end

    // Status is sampled live in the ack cycle, memory data lands on the same edge as ack
    always_comb
    begin
        wb_rsp.ack = ack_q;
        case (rd_sel_q)
            SEL_MEM:    wb_rsp.dat = mem_a_rd_data;
            SEL_EN:     wb_rsp.dat = DW'(csr.hc_en);
            SEL_RFRAME: wb_rsp.dat = DW'(csr.hc_read_frame);
            SEL_WFRAME: wb_rsp.dat = DW'(csr.hc_write_frame);
            SEL_STATUS: wb_rsp.dat = DW'(status);
            default:    wb_rsp.dat = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            csr.hc_en <= 1'b0;
        else if (wr_hit(hc_csr_pkg::CSR_HC_EN))
            csr.hc_en <= wb_req.dat[0];
    end

    // Frames come up undefined; software always sets them before a test
    always_ff @(posedge clk)
    begin
        if (wr_hit(hc_csr_pkg::CSR_HC_READ_FRAME))
            csr.hc_read_frame <= wb_req.dat[hc_csr_pkg::FRAME_W-1:0];
        if (wr_hit(hc_csr_pkg::CSR_HC_WRITE_FRAME))
            csr.hc_write_frame <= wb_req.dat[hc_csr_pkg::FRAME_W-1:0];
    end

    // The length rides along with the start write, zero meaning the whole memory
    always_ff @(posedge clk)
    begin
        if (wr_hit(hc_csr_pkg::CSR_HC_ENABLE_TEST))
        begin
            if (wb_req.dat[LW-1:0] == '0)
                csr.hc_test_len <= LW'(hc_csr_pkg::MAX_LEN);
            else
                csr.hc_test_len <= wb_req.dat[LW-1:0];
        end
    end

    // Start pulse lasts one cycle and is suppressed while the channel is disabled
    always_ff @(posedge clk)
    begin
        if (reset)
            csr.hc_enable_test <= 1'b0;
        else
            csr.hc_enable_test <= wr_hit(hc_csr_pkg::CSR_HC_ENABLE_TEST) && csr.hc_en;
    end

endmodule

// ==== verilog/hc_csr_pkg.sv ====
// Register map of the loopback engine and the CSR state broadcast to the copy logic
package hc_csr_pkg;

    // Register offsets in words, relative to the block's base address
    localparam int CSR_HC_EN          = 0;
    localparam int CSR_HC_READ_FRAME  = 1;
    localparam int CSR_HC_WRITE_FRAME = 2;
    localparam int CSR_HC_ENABLE_TEST = 3;
    localparam int CSR_HC_STATUS      = 4;

    // The line memory appears at this word offset and spans 64 words
    localparam int MEM_WINDOW = 64;

    // A frame is a word offset into the line memory
    localparam int FRAME_W = 6;

    // Test length runs 1 to 64, so it needs one bit more than a frame
    localparam int LEN_W = 7;

    // A length field of zero stands for the full memory
    localparam int MAX_LEN = 64;

    // Width of the finished-test counter
    localparam int TESTS_W = 8;

    // State written by the host and seen by the engine every cycle
    typedef struct packed {
        logic               hc_en;
        logic [FRAME_W-1:0] hc_read_frame;
        logic [FRAME_W-1:0] hc_write_frame;
        // Start pulse, high for one cycle only
        logic               hc_enable_test;
        logic [LEN_W-1:0]   hc_test_len;
    } hc_csrs_t;

    // Engine state reported back through the status register
    typedef struct packed {
        logic               busy;
        logic [TESTS_W-1:0] tests_done;
    } hc_status_t;

endpackage

// ==== verilog/hc_bus_pkg.sv ====
// Bus-side types shared by the loopback engine: Wishbone request/response and line-memory ports
package hc_bus_pkg;

    // Word address width of the Wishbone slave window
    localparam int ADDR_W = 10;
    // Width of every data word on the bus and in the line memory
    localparam int DATA_W = 32;
    // Line memory holds 2**MEM_AW words
    localparam int MEM_AW = 6;

    // Request driven by the Wishbone master, held until ack is seen
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // Slave response; dat is only meaningful while ack is high on a read
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // One access to the line memory, valid for the cycle in which en is high
    typedef struct packed {
        logic              en;
        logic              we;
        logic [MEM_AW-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_port_t;

endpackage
